// File: Makefile
VERILATOR ?= verilator
TOP ?= mips_cpu_tb
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps
SIM_ARGS ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || { echo "no result found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
source/mips_pkg.sv
source/instr_register.sv
source/cpu_control.sv
source/register_file.sv
source/alu.sv
source/mips_cpu.sv
verification/tb_clock.sv
verification/mips_cpu_asserts.sv
verification/mips_cpu_tb.sv

// File: source/alu.sv
`default_nettype none

module alu (
    input  mips_pkg::alu_op_t               operation,
    input  logic [mips_pkg::word_width-1:0] a,
    input  logic [mips_pkg::word_width-1:0] b,
    output logic [mips_pkg::word_width-1:0] result,
    output logic                            zero
);
    import mips_pkg::*;

    logic less;

    // signed compare for slt
    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (operation)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_slt: result = {{(word_width-1){1'b0}}, less};
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

// File: source/cpu_control.sv
`default_nettype none

module cpu_control (
    input  logic                 clk,
    input  logic                 reset,
    input  mips_pkg::opcode_t    op,
    input  mips_pkg::funct_t     funct,
    input  logic                 alu_zero,
    input  logic                 waitrequest,
    output mips_pkg::cpu_state_t state,
    output logic                 read,
    output logic                 write,
    output logic                 ir_load,
    output logic                 pc_write,
    output logic                 branch_taken,
    output logic                 jump,
    output logic                 reg_write,
    output logic                 reg_dest_rd,
    output logic                 mem_to_reg,
    output logic                 alu_src_imm,
    output mips_pkg::alu_op_t    alu_op,
    output logic                 addr_load
);
    import mips_pkg::*;

    cpu_state_t next_state;
    logic       fetch_done;
    logic       mem_access;

    assign fetch_done = (state == state_fetch) && !waitrequest;
    assign mem_access = (op == op_lw) || (op == op_sw);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= state_fetch;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            state_fetch: begin
                if (!waitrequest) next_state = state_execute;
            end
            state_execute: begin
                next_state = mem_access ? state_memory : state_fetch;
            end
            state_memory: begin
                if (!waitrequest) next_state = state_fetch;
            end
            default: next_state = state_fetch;
        endcase
    end

    // bus strobes stay low while reset is held
    assign read = !reset && ((state == state_fetch) ||
                             (state == state_memory && op == op_lw));
    assign write = !reset && (state == state_memory) && (op == op_sw);

    assign ir_load = fetch_done;
    assign branch_taken = (state == state_execute) && (op == op_beq) && alu_zero;
    assign jump = (state == state_execute) && (op == op_j);
    assign pc_write = fetch_done || branch_taken || jump;
    assign addr_load = (state == state_execute) && mem_access;

    // register writeback at end of execute or at the completing lw edge
    assign reg_write = ((state == state_execute) &&
                        ((op == op_special) || (op == op_addiu))) ||
                       ((state == state_memory) && (op == op_lw) && !waitrequest);
    assign reg_dest_rd = (op == op_special);
    assign mem_to_reg = (state == state_memory);
    assign alu_src_imm = (op == op_addiu) || mem_access;

    always_comb begin
        alu_op = alu_add;
        if (op == op_special) begin
            case (funct)
                funct_subu: alu_op = alu_sub;
                funct_and:  alu_op = alu_and;
                funct_or:   alu_op = alu_or;
                funct_slt:  alu_op = alu_slt;
                default:    alu_op = alu_add;
            endcase
        end else if (op == op_beq) begin
            // equality test through the zero flag
            alu_op = alu_sub;
        end
    end

endmodule

`default_nettype wire

// File: source/instr_register.sv
`default_nettype none

module instr_register (
    input  logic                            clk,
    input  logic                            reset,
    input  mips_pkg::cpu_state_t            state,
    input  logic                            ir_load,
    input  logic [mips_pkg::word_width-1:0] readdata,
    output mips_pkg::opcode_t               op,
    output logic [4:0]                      rs,
    output logic [4:0]                      rt,
    output logic [4:0]                      rd,
    output mips_pkg::funct_t                funct,
    output logic [15:0]                     immediate,
    output logic [25:0]                     target
);
    import mips_pkg::*;

    // stored instruction word
    logic [word_width-1:0] instr;
    // word the fields are cut from
    logic [word_width-1:0] word;

    always_ff @(posedge clk) begin
        if (reset) begin
            instr <= '0;
        end else if (ir_load) begin
            instr <= readdata;
        end
    end

    // during fetch the memory word goes straight through, so the
    // register file can start its reads on the completing edge
    always_comb begin
        if (state == state_fetch) begin
            word = readdata;
        end else begin
            word = instr;
        end
    end

    always_comb begin
        op = opcode_t'(word[31:26]);
        rs = word[25:21];
        rt = word[20:16];
        rd = word[15:11];
        funct = funct_t'(word[5:0]);
        immediate = word[15:0];
        target = word[25:0];
    end

endmodule

`default_nettype wire

// File: source/mips_cpu.sv
`default_nettype none

module mips_cpu (
    input  logic                            clk,
    input  logic                            reset,
    output logic [mips_pkg::word_width-1:0] address,
    output logic                            read,
    output logic                            write,
    output logic [mips_pkg::word_width-1:0] writedata,
    input  logic [mips_pkg::word_width-1:0] readdata,
    input  logic                            waitrequest
);
    import mips_pkg::*;

    localparam int ra_bits = $clog2(reg_count);

    cpu_state_t state;
    opcode_t    op;
    funct_t     funct;
    alu_op_t    alu_op;

    logic ir_load, pc_write, branch_taken, jump;
    logic reg_write, reg_dest_rd, mem_to_reg, alu_src_imm, addr_load;
    logic alu_zero;

    logic [ra_bits-1:0] rs, rt, rd, write_addr;
    logic [15:0] immediate;
    logic [25:0] target;

    logic [word_width-1:0] pc, data_addr, store_data;
    logic [word_width-1:0] imm_ext, branch_target, jump_target;
    logic [word_width-1:0] data_a, data_b, alu_b, alu_result, write_data;

    cpu_control control (
        .clk(clk), .reset(reset), .op(op), .funct(funct), .alu_zero(alu_zero),
        .waitrequest(waitrequest), .state(state), .read(read), .write(write),
        .ir_load(ir_load), .pc_write(pc_write), .branch_taken(branch_taken),
        .jump(jump), .reg_write(reg_write), .reg_dest_rd(reg_dest_rd),
        .mem_to_reg(mem_to_reg), .alu_src_imm(alu_src_imm), .alu_op(alu_op),
        .addr_load(addr_load)
    );

    instr_register ir (
        .clk(clk), .reset(reset), .state(state), .ir_load(ir_load),
        .readdata(readdata), .op(op), .rs(rs), .rt(rt), .rd(rd), .funct(funct),
        .immediate(immediate), .target(target)
    );

    register_file regs (
        .clk(clk), .reset(reset), .read_addr_a(rs), .read_addr_b(rt),
        .data_a(data_a), .data_b(data_b), .write_enable(reg_write),
        .write_addr(write_addr), .write_data(write_data)
    );

    alu alu_unit (
        .operation(alu_op), .a(data_a), .b(alu_b), .result(alu_result),
        .zero(alu_zero)
    );

    // operand and writeback selection
    assign imm_ext = {{16{immediate[15]}}, immediate};
    assign alu_b = alu_src_imm ? imm_ext : data_b;
    assign write_addr = reg_dest_rd ? rd : rt;
    assign write_data = mem_to_reg ? readdata : alu_result;

    // pc already points past the branch during execute
    assign branch_target = pc + {imm_ext[word_width-3:0], 2'b00};
    assign jump_target = {pc[31:28], target, 2'b00};

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (pc_write) begin
            if (jump) begin
                pc <= jump_target;
            end else if (branch_taken) begin
                pc <= branch_target;
            end else begin
                pc <= pc + 32'd4;
            end
        end
    end

    // effective address and store data for lw and sw
    always_ff @(posedge clk) begin
        if (addr_load) begin
            data_addr <= alu_result;
            store_data <= data_b;
        end
    end

    assign address = (state == state_memory) ? data_addr : pc;
    assign writedata = store_data;

endmodule

`default_nettype wire

// File: source/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // fixed sizes of the instruction set
    localparam int word_width = 32;
    localparam int reg_count = 32;
    localparam logic [word_width-1:0] reset_pc = 32'h0000_0000;

    // primary opcode, bits 31:26
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_beq     = 6'h04,
        op_addiu   = 6'h09,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_t;

    // function field of the special opcode, bits 5:0
    typedef enum logic [5:0] {
        funct_addu = 6'h21,
        funct_subu = 6'h23,
        funct_and  = 6'h24,
        funct_or   = 6'h25,
        funct_slt  = 6'h2a
    } funct_t;

    // controller steps, two bits wide
    typedef enum logic [1:0] {
        state_fetch   = 2'd0,
        state_execute = 2'd1,
        state_memory  = 2'd2
    } cpu_state_t;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4
    } alu_op_t;

endpackage

`default_nettype wire

// File: source/register_file.sv
`default_nettype none

module register_file (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  read_addr_a,
    input  logic [4:0]  read_addr_b,
    output logic [31:0] data_a,
    output logic [31:0] data_b,
    input  logic        write_enable,
    input  logic [4:0]  write_addr,
    input  logic [31:0] write_data
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
            data_a <= '0;
            data_b <= '0;
        end else begin
            // register zero is never written
            if (write_enable && write_addr != 5'd0) begin
                regs[write_addr] <= write_data;
            end
            data_a <= regs[read_addr_a];
            data_b <= regs[read_addr_b];
        end
    end

endmodule

`default_nettype wire

// File: verification/mips_cpu_asserts.sv
`default_nettype none

module mips_cpu_asserts (
    input  logic                            clk,
    input  logic                            reset,
    input  mips_pkg::cpu_state_t            state,
    input  logic [mips_pkg::word_width-1:0] address,
    input  logic                            read,
    input  logic                            write,
    input  logic [mips_pkg::word_width-1:0] writedata,
    input  logic                            waitrequest
);
    timeunit 1ns;
    timeprecision 100ps;
    import mips_pkg::*;

    // raised by any failing check below, watched by the testbench top
    logic failed = 1'b0;

    // bus strobes quiet during reset
    reset_quiet: assert property (@(posedge clk) reset |-> !read && !write)
    else begin
        failed = 1'b1;
        $error("read or write high while reset is asserted");
    end

    // first cycle out of reset is a fetch from reset_pc
    first_fetch: assert property (@(posedge clk)
        $fell(reset) |-> read && !write && address == reset_pc)
    else begin
        failed = 1'b1;
        $error("first bus cycle after reset is not a read at the reset address");
    end

    // pending transfer frozen while the memory stalls
    hold_on_wait: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=>
            $stable(address) && $stable(read) && $stable(write) && $stable(writedata))
    else begin
        failed = 1'b1;
        $error("bus outputs changed while waitrequest was high");
    end

    no_read_and_write: assert property (@(posedge clk) disable iff (reset) !(read && write))
    else begin
        failed = 1'b1;
        $error("read and write high in the same cycle");
    end

    fetch_aligned: assert property (@(posedge clk) disable iff (reset)
        read && state == state_fetch |-> address[1:0] == 2'b00)
    else begin
        failed = 1'b1;
        $error("fetch address is not word aligned");
    end

endmodule

bind mips_cpu mips_cpu_asserts protocol_checks (
    .clk(clk),
    .reset(reset),
    .state(state),
    .address(address),
    .read(read),
    .write(write),
    .writedata(writedata),
    .waitrequest(waitrequest)
);

`default_nettype wire

// File: verification/mips_cpu_tb.sv
`default_nettype none

module mips_cpu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import mips_pkg::*;

    localparam int store_total = 9;
    localparam logic [31:0] loop_addr = 32'h0000_005c;
    // three steps per instruction, each bus step allowed eight wait cycles
    localparam int instr_cycles = 3 + 2 * 8;
    localparam int timeout_cycles = 16 + 200 * instr_cycles;

    logic        clk;
    logic        reset = 1'b1;
    logic        waitrequest = 1'b0;
    logic        read;
    logic        write;
    logic [31:0] address;
    logic [31:0] writedata;
    logic [31:0] readdata;

    logic [31:0] mem [256];
    logic [31:0] store_addr [16];
    logic [31:0] store_data [16];
    int          store_listed = 0;
    logic [3:0]  store_count;
    logic [31:0] exp_address;
    logic [31:0] exp_data;
    logic [31:0] expected_fetch;
    int          loop_fetches = 0;
    logic [31:0] lfsr = 32'h0399_6399;
    logic        wait_a;
    logic        wait_b;

    tb_clock clock_gen (.clk(clk));

    mips_cpu uut (
        .clk(clk), .reset(reset), .address(address), .read(read), .write(write),
        .writedata(writedata), .readdata(readdata), .waitrequest(waitrequest)
    );

    function automatic logic [31:0] encode_r(funct_t funct, logic [4:0] rd,
                                             logic [4:0] rs, logic [4:0] rt);
        return {op_special, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encode_i(opcode_t op, logic [4:0] rt,
                                             logic [4:0] rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encode_j(logic [25:0] target);
        return {op_j, target};
    endfunction

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // redirects taken from the program listing below
    function automatic logic [31:0] following_fetch(logic [31:0] pc);
        case (pc)
            32'h0000_0040: return 32'h0000_0048;
            32'h0000_0050: return 32'h0000_0058;
            32'h0000_005c: return 32'h0000_005c;
            default:       return pc + 32'd4;
        endcase
    endfunction

    task automatic add_expected_store(logic [31:0] addr, logic [31:0] data);
        store_addr[store_listed] = addr;
        store_data[store_listed] = data;
        store_listed++;
    endtask

    // memory model, combinational read and write on the completing edge
    assign readdata = mem[address[9:2]];

    always @(posedge clk) begin
        if (!reset && write && !waitrequest) begin
            mem[address[9:2]] <= writedata;
        end
    end

    // roughly one stall cycle in four
    always @(negedge clk) begin
        lfsr = lfsr_next(lfsr);
        wait_a = lfsr[0];
        lfsr = lfsr_next(lfsr);
        wait_b = lfsr[0];
        waitrequest <= wait_a & wait_b;
    end

    always @(posedge clk) begin
        if (reset) begin
            store_count <= '0;
            expected_fetch <= reset_pc;
        end else begin
            if (write && !waitrequest) begin
                store_count <= store_count + 4'd1;
            end
            if (uut.ir_load) begin
                expected_fetch <= following_fetch(expected_fetch);
                if (address == loop_addr) begin
                    loop_fetches <= loop_fetches + 1;
                end
            end
        end
    end

    assign exp_address = store_addr[store_count];
    assign exp_data = store_data[store_count];

    store_count_check: assert property (@(posedge clk) disable iff (reset)
        write && !waitrequest |-> store_count < 4'(store_total))
    else begin
        $display("a store happened after all expected stores were seen");
        $display("Result: FAILED");
        $fatal(1);
    end

    store_address_check: assert property (@(posedge clk) disable iff (reset)
        write && !waitrequest |-> address == exp_address)
    else begin
        $display("FAIL time=%0t signal=address expected=%h actual=%h",
                 $time, $sampled(exp_address), $sampled(address));
        $display("Result: FAILED");
        $fatal(1);
    end

    store_data_check: assert property (@(posedge clk) disable iff (reset)
        write && !waitrequest |-> writedata == exp_data)
    else begin
        $display("FAIL time=%0t signal=writedata expected=%h actual=%h",
                 $time, $sampled(exp_data), $sampled(writedata));
        $display("Result: FAILED");
        $fatal(1);
    end

    fetch_address_check: assert property (@(posedge clk) disable iff (reset)
        uut.ir_load |-> address == expected_fetch)
    else begin
        $display("FAIL time=%0t signal=address expected=%h actual=%h",
                 $time, $sampled(expected_fetch), $sampled(address));
        $display("Result: FAILED");
        $fatal(1);
    end

    // failure flag of the bound protocol checks
    always @(posedge clk) begin
        if (uut.protocol_checks.failed) begin
            $display("a bus protocol assertion failed");
            $display("Result: FAILED");
            $fatal(1);
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("the program did not reach its final loop in time");
        $display("Result: FAILED");
        $fatal(1);
    end

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h5a00_0000 | (i << 2);
        end
        // r1 = 0x7fff, r2 = -3
        mem[0] = encode_i(op_addiu, 5'd1, 5'd0, 16'h7fff);
        mem[1] = encode_i(op_addiu, 5'd2, 5'd0, 16'hfffd);
        mem[2] = encode_r(funct_addu, 5'd3, 5'd1, 5'd2);
        mem[3] = encode_i(op_sw, 5'd3, 5'd0, 16'h0200);
        mem[4] = encode_r(funct_subu, 5'd4, 5'd2, 5'd1);
        mem[5] = encode_i(op_sw, 5'd4, 5'd0, 16'h0204);
        mem[6] = encode_r(funct_and, 5'd5, 5'd1, 5'd2);
        mem[7] = encode_r(funct_or, 5'd6, 5'd1, 5'd2);
        mem[8] = encode_i(op_sw, 5'd5, 5'd0, 16'h0208);
        mem[9] = encode_i(op_sw, 5'd6, 5'd0, 16'h020c);
        mem[10] = encode_r(funct_slt, 5'd7, 5'd2, 5'd1);
        mem[11] = encode_r(funct_slt, 5'd8, 5'd1, 5'd2);
        mem[12] = encode_i(op_sw, 5'd7, 5'd0, 16'h0210);
        mem[13] = encode_i(op_sw, 5'd8, 5'd0, 16'h0214);
        mem[14] = encode_i(op_lw, 5'd9, 5'd0, 16'h0204);
        mem[15] = encode_i(op_sw, 5'd9, 5'd0, 16'h0218);
        // taken beq skips the store at 0x44
        mem[16] = encode_i(op_beq, 5'd0, 5'd8, 16'h0001);
        mem[17] = encode_i(op_sw, 5'd1, 5'd0, 16'h021c);
        mem[18] = encode_i(op_beq, 5'd0, 5'd7, 16'h0001);
        mem[19] = encode_i(op_sw, 5'd7, 5'd0, 16'h021c);
        mem[20] = encode_j(26'h000_0016);
        mem[21] = encode_i(op_sw, 5'd1, 5'd0, 16'h0220);
        mem[22] = encode_i(op_sw, 5'd2, 5'd0, 16'h0220);
        mem[23] = encode_j(26'h000_0017);

        add_expected_store(32'h0000_0200, 32'h0000_7ffc);
        add_expected_store(32'h0000_0204, 32'hffff_7ffe);
        add_expected_store(32'h0000_0208, 32'h0000_7ffd);
        add_expected_store(32'h0000_020c, 32'hffff_ffff);
        add_expected_store(32'h0000_0210, 32'h0000_0001);
        add_expected_store(32'h0000_0214, 32'h0000_0000);
        add_expected_store(32'h0000_0218, 32'hffff_7ffe);
        add_expected_store(32'h0000_021c, 32'h0000_0001);
        add_expected_store(32'h0000_0220, 32'hffff_fffd);

        repeat (16) @(negedge clk);
        reset = 1'b0;
        wait (loop_fetches >= 2);
        @(negedge clk);
        if (uut.protocol_checks.failed) begin
            $display("a bus protocol assertion failed");
            $display("Result: FAILED");
            $fatal(1);
        end else if (store_count == 4'(store_total)) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("the program reached its final loop with stores missing");
            $display("Result: FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2ns clk = ~clk;
    end

endmodule

`default_nettype wire
